//--- hdl/rpc_dram_pkg.sv
// DRAM-side types shared by the PHY stages and the testbench
// Covers the DB beat format, the write mask and the 32-bit command word

package rpc_dram_pkg;

  ////////////////////////////////////////////////////////////////////
  // DB bus widths
  ////////////////////////////////////////////////////////////////////

  // One pin group edge and one full DDR pair
  localparam int unsigned DB_HALF_W  = 16;
  localparam int unsigned DB_SLICE_W = 2 * DB_HALF_W;
  // Burst write mask, sent as two DB beats
  localparam int unsigned MASK_W     = 64;

  typedef logic [DB_HALF_W-1:0]  db_half_t;
  // Upper half on the rising edge, lower half on the falling edge
  typedef logic [DB_SLICE_W-1:0] db_slice_t;
  typedef logic [MASK_W-1:0]     mask_t;

  ////////////////////////////////////////////////////////////////////
  // Command word
  ////////////////////////////////////////////////////////////////////

  // Reserved opcode behaves as a command-only request
  typedef enum logic [1:0] {
    op_cmd_only = 2'b00,
    op_write    = 2'b01,
    op_read     = 2'b10,
    op_rsvd     = 2'b11
  } opcode_e;

  // Number of words in the burst minus one
  typedef logic [2:0]  burst_len_t;
  // Passed to the DRAM untouched
  typedef logic [26:0] dram_addr_t;

  typedef struct packed {
    opcode_e    opcode;
    burst_len_t burst_len;
    dram_addr_t addr;
  } cmd_t;

endpackage

//--- hdl/rpc_phy_pkg.sv
// Internal PHY types passed between the sequencer and the data stages
// Not visible on the DRAM side

package rpc_phy_pkg;

  ////////////////////////////////////////////////////////////////////
  // Sequencer
  ////////////////////////////////////////////////////////////////////

  typedef enum logic [2:0] {
    st_idle,
    st_cmd,
    st_mask_hi,
    st_mask_lo,
    st_wr_data,
    st_rd_wait
  } seq_state_e;

  ////////////////////////////////////////////////////////////////////
  // Stage controls
  ////////////////////////////////////////////////////////////////////

  // What the transmit mux puts on DB in the following cycle
  typedef enum logic [2:0] {
    beat_none,
    beat_command,
    beat_mask_hi,
    beat_mask_lo,
    beat_data
  } beat_kind_e;

  // Beat position inside a word, enough for 512-bit words
  typedef logic [3:0] beat_idx_t;

  typedef struct packed {
    beat_kind_e kind;
    beat_idx_t  idx;
  } tx_sel_t;

  // rd_active opens the packer, last_word tags the final word
  typedef struct packed {
    logic rd_active;
    logic last_word;
  } rx_ctrl_t;

endpackage

//--- hdl/rpc_burst_seq.sv
// Burst sequencer of the PHY
// Accepts one command at a time and orders the command, mask and data beats
// Beat selects go out one cycle ahead of the DB register in the transmit mux

`timescale 1ns/1ps

module rpc_burst_seq #(
  parameter int unsigned WORD_WIDTH = 256
) (
  input  logic                  clk_0_i,
  input  logic                  rst_ni,
  input  rpc_dram_pkg::cmd_t    cmd_i,
  input  logic                  cmd_valid_i,
  output logic                  cmd_ready_o,
  input  logic                  word_done_i,
  output logic                  data_ready_o,
  output logic                  cs_n_o,
  output logic                  stb_o,
  output logic                  db_oe_o,
  output rpc_phy_pkg::tx_sel_t  tx_sel_o,
  output rpc_phy_pkg::rx_ctrl_t rx_ctrl_o,
  output rpc_dram_pkg::cmd_t    cmd_q_o
);
  import rpc_dram_pkg::*;
  import rpc_phy_pkg::*;

  localparam int unsigned BEATS     = WORD_WIDTH / DB_SLICE_W;
  localparam beat_idx_t   LAST_BEAT = beat_idx_t'(BEATS - 1);

  seq_state_e state_q, state_d;
  cmd_t       cmd_q;
  beat_idx_t  beat_q, beat_d;
  burst_len_t word_q, word_d;
  logic       accept;
  logic       last_word;

  // Only idle takes a new command
  assign cmd_ready_o = (state_q == st_idle);
  assign accept      = cmd_valid_i && cmd_ready_o;
  // Word counter reached the burst length of the held command
  assign last_word   = (word_q == cmd_q.burst_len);

  // During acceptance the mux needs the live word for the command beat
  assign cmd_q_o = accept ? cmd_i : cmd_q;

  always_ff @(posedge clk_0_i) begin
    if (accept) begin
      cmd_q <= cmd_i;
    end
  end

  ////////////////////////////////////////////////////////////////////
  // Burst FSM
  ////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d       = state_q;
    beat_d        = beat_q;
    word_d        = word_q;
    tx_sel_o.kind = beat_none;
    tx_sel_o.idx  = '0;
    data_ready_o  = 1'b0;
    case (state_q)
      st_idle: begin
        beat_d = '0;
        word_d = '0;
        if (accept) begin
          tx_sel_o.kind = beat_command;
          state_d       = st_cmd;
        end
      end
      st_cmd: begin
        case (cmd_q.opcode)
          op_write: begin
            tx_sel_o.kind = beat_mask_hi;
            state_d       = st_mask_hi;
          end
          op_read: state_d = st_rd_wait;
          // Single beat only
          op_cmd_only, op_rsvd: state_d = st_idle;
        endcase
      end
      st_mask_hi: begin
        tx_sel_o.kind = beat_mask_lo;
        state_d       = st_mask_lo;
      end
      st_mask_lo: begin
        // First word requested while the second mask beat is out
        tx_sel_o.kind = beat_data;
        data_ready_o  = 1'b1;
        state_d       = st_wr_data;
      end
      st_wr_data: begin
        if (beat_q != LAST_BEAT) begin
          tx_sel_o.kind = beat_data;
          tx_sel_o.idx  = beat_q + beat_idx_t'(1);
          beat_d        = beat_q + beat_idx_t'(1);
        end else if (!last_word) begin
          // Next word fetched in the last beat of this one
          tx_sel_o.kind = beat_data;
          data_ready_o  = 1'b1;
          beat_d        = '0;
          word_d        = word_q + burst_len_t'(1);
        end else begin
          state_d = st_idle;
        end
      end
      st_rd_wait: begin
        // Latency is open, the packer tells when a word is complete
        if (word_done_i) begin
          if (last_word) begin
            state_d = st_idle;
          end else begin
            word_d = word_q + burst_len_t'(1);
          end
        end
      end
      default: state_d = st_idle;
    endcase
  end

  always_ff @(posedge clk_0_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= st_idle;
      beat_q  <= '0;
      word_q  <= '0;
    end else begin
      state_q <= state_d;
      beat_q  <= beat_d;
      word_q  <= word_d;
    end
  end

  // Pin controls straight from the state
  assign stb_o   = (state_q == st_cmd);
  assign cs_n_o  = (state_q == st_idle);
  assign db_oe_o = (state_q inside {st_cmd, st_mask_hi, st_mask_lo, st_wr_data});

  assign rx_ctrl_o.rd_active = (state_q == st_rd_wait);
  assign rx_ctrl_o.last_word = last_word;

  // STB marks exactly one beat per command
  stb_one_cycle: assert property (@(posedge clk_0_i) disable iff (!rst_ni)
    stb_o |=> !stb_o)
    else $error("stb_o held for more than one cycle");

  // DB is never driven outside the chip-select window
  oe_inside_cs: assert property (@(posedge clk_0_i) disable iff (!rst_ni)
    db_oe_o |-> !cs_n_o)
    else $error("db_oe_o high with cs_n_o deasserted");

endmodule

//--- hdl/rpc_tx_mux.sv
// Transmit side of the PHY
// Picks command, mask or data beat from the sequencer select and registers it onto DB

`timescale 1ns/1ps

module rpc_tx_mux #(
  parameter int unsigned WORD_WIDTH = 256
) (
  input  logic                   clk_0_i,
  input  logic                   rst_ni,
  input  rpc_phy_pkg::tx_sel_t   tx_sel_i,
  input  rpc_dram_pkg::cmd_t     cmd_i,
  input  rpc_dram_pkg::mask_t    mask_i,
  input  logic [WORD_WIDTH-1:0]  data_i,
  input  logic                   data_take_i,
  output rpc_dram_pkg::db_slice_t db_o
);
  import rpc_dram_pkg::*;
  import rpc_phy_pkg::*;

  localparam int unsigned BEATS = WORD_WIDTH / DB_SLICE_W;

  logic [WORD_WIDTH-1:0] word_q;
  logic [WORD_WIDTH-1:0] word_src;
  mask_t                 mask_q;
  db_slice_t             data_beat;
  db_slice_t             beat_d;

  // Low 16 bits leave first, on the rising edge
  function automatic db_slice_t swap_halves(db_slice_t s);
    db_half_t rise_half;
    db_half_t fall_half;
    rise_half = s[DB_HALF_W-1:0];
    fall_half = s[DB_SLICE_W-1:DB_HALF_W];
    return {rise_half, fall_half};
  endfunction

  ////////////////////////////////////////////////////////////////////
  // Word and mask holding
  ////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_0_i) begin
    if (data_take_i) begin
      word_q <= data_i;
    end
  end

  // Mask sampled together with the command beat
  always_ff @(posedge clk_0_i) begin
    if (tx_sel_i.kind == beat_command) begin
      mask_q <= mask_i;
    end
  end

  ////////////////////////////////////////////////////////////////////
  // Beat selection
  ////////////////////////////////////////////////////////////////////

  always_comb begin
    // Beat 0 of a word comes straight from data_i in its request cycle
    word_src  = data_take_i ? data_i : word_q;
    data_beat = word_src[tx_sel_i.idx * DB_SLICE_W +: DB_SLICE_W];
    case (tx_sel_i.kind)
      beat_command: beat_d = db_slice_t'(cmd_i);
      beat_mask_hi: beat_d = swap_halves(mask_q[DB_SLICE_W-1:0]);
      beat_mask_lo: beat_d = swap_halves(mask_q[MASK_W-1:DB_SLICE_W]);
      beat_data:    beat_d = swap_halves(data_beat);
      default:      beat_d = '0;
    endcase
  end

  always_ff @(posedge clk_0_i or negedge rst_ni) begin
    if (!rst_ni) begin
      db_o <= '0;
    end else begin
      db_o <= beat_d;
    end
  end

  // Sequencer must stay inside the configured word
  data_idx_in_word: assert property (@(posedge clk_0_i) disable iff (!rst_ni)
    (tx_sel_i.kind == beat_data) |-> (tx_sel_i.idx < BEATS))
    else $error("data beat index beyond word width");

endmodule

//--- hdl/rpc_rx_pack.sv
// Receive side of the PHY
// Collects read slices in arrival order into a word and flags it for one cycle

`timescale 1ns/1ps

module rpc_rx_pack #(
  parameter int unsigned WORD_WIDTH = 256
) (
  input  logic                    clk_0_i,
  input  logic                    rst_ni,
  input  rpc_phy_pkg::rx_ctrl_t   rx_ctrl_i,
  input  rpc_dram_pkg::db_slice_t rd_slice_i,
  input  logic                    rd_slice_valid_i,
  output logic                    word_done_o,
  output logic [WORD_WIDTH-1:0]   data_o,
  output logic                    data_valid_o,
  output logic                    data_last_o
);
  import rpc_dram_pkg::*;
  import rpc_phy_pkg::*;

  localparam int unsigned BEATS      = WORD_WIDTH / DB_SLICE_W;
  localparam beat_idx_t   LAST_SLICE = beat_idx_t'(BEATS - 1);

  beat_idx_t             slice_q;
  logic [WORD_WIDTH-1:0] word_q;
  logic                  take;

  // Stray slices outside a read are dropped here
  assign take        = rd_slice_valid_i && rx_ctrl_i.rd_active;
  assign word_done_o = take && (slice_q == LAST_SLICE);

  ////////////////////////////////////////////////////////////////////
  // Slice position
  ////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_0_i or negedge rst_ni) begin
    if (!rst_ni) begin
      slice_q <= '0;
    end else if (!rx_ctrl_i.rd_active) begin
      slice_q <= '0;
    end else if (take) begin
      slice_q <= word_done_o ? '0 : slice_q + beat_idx_t'(1);
    end
  end

  // Slice s lands at bits 32s+31:32s
  always_ff @(posedge clk_0_i) begin
    if (take) begin
      word_q[slice_q * DB_SLICE_W +: DB_SLICE_W] <= rd_slice_i;
    end
  end

  assign data_o = word_q;

  ////////////////////////////////////////////////////////////////////
  // Word flags, one cycle after the closing slice
  ////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_0_i or negedge rst_ni) begin
    if (!rst_ni) begin
      data_valid_o <= 1'b0;
      data_last_o  <= 1'b0;
    end else begin
      data_valid_o <= word_done_o;
      data_last_o  <= word_done_o && rx_ctrl_i.last_word;
    end
  end

  // No ready on the read side, so a word is offered once
  valid_single: assert property (@(posedge clk_0_i) disable iff (!rst_ni)
    data_valid_o |=> !data_valid_o)
    else $error("data_valid_o held for more than one cycle");

endmodule

//--- hdl/rpc_phy.sv
// Controller-side PHY core for the reduced-pin-count DRAM
// Chains the burst sequencer to the transmit mux and the receive packer
// DDR conversion of db_o and capture of rd_slice_i happen at the pad level

`timescale 1ns/1ps

module rpc_phy #(
  parameter int unsigned WORD_WIDTH = 256
) (
  input  logic                    clk_0_i,
  input  logic                    rst_ni,
  // Command handshake
  input  rpc_dram_pkg::cmd_t      cmd_i,
  input  logic                    cmd_valid_i,
  output logic                    cmd_ready_o,
  // Write data, one word per request
  input  logic [WORD_WIDTH-1:0]   data_i,
  input  rpc_dram_pkg::mask_t     mask_i,
  output logic                    data_ready_o,
  // Read data, no back-pressure
  output logic [WORD_WIDTH-1:0]   data_o,
  output logic                    data_valid_o,
  output logic                    data_last_o,
  // DRAM side
  output logic                    cs_n_o,
  output logic                    stb_o,
  output logic                    db_oe_o,
  output rpc_dram_pkg::db_slice_t db_o,
  input  rpc_dram_pkg::db_slice_t rd_slice_i,
  input  logic                    rd_slice_valid_i
);
  import rpc_dram_pkg::*;
  import rpc_phy_pkg::*;

  cmd_t     cmd_q;
  tx_sel_t  tx_sel;
  rx_ctrl_t rx_ctrl;
  logic     word_done;

  rpc_burst_seq #(
    .WORD_WIDTH (WORD_WIDTH)
  ) seq_i (
    .clk_0_i      (clk_0_i),
    .rst_ni       (rst_ni),
    .cmd_i        (cmd_i),
    .cmd_valid_i  (cmd_valid_i),
    .cmd_ready_o  (cmd_ready_o),
    .word_done_i  (word_done),
    .data_ready_o (data_ready_o),
    .cs_n_o       (cs_n_o),
    .stb_o        (stb_o),
    .db_oe_o      (db_oe_o),
    .tx_sel_o     (tx_sel),
    .rx_ctrl_o    (rx_ctrl),
    .cmd_q_o      (cmd_q)
  );

  // Word request doubles as the load strobe of the word register
  rpc_tx_mux #(
    .WORD_WIDTH (WORD_WIDTH)
  ) tx_mux_i (
    .clk_0_i     (clk_0_i),
    .rst_ni      (rst_ni),
    .tx_sel_i    (tx_sel),
    .cmd_i       (cmd_q),
    .mask_i      (mask_i),
    .data_i      (data_i),
    .data_take_i (data_ready_o),
    .db_o        (db_o)
  );

  rpc_rx_pack #(
    .WORD_WIDTH (WORD_WIDTH)
  ) rx_pack_i (
    .clk_0_i          (clk_0_i),
    .rst_ni           (rst_ni),
    .rx_ctrl_i        (rx_ctrl),
    .rd_slice_i       (rd_slice_i),
    .rd_slice_valid_i (rd_slice_valid_i),
    .word_done_o      (word_done),
    .data_o           (data_o),
    .data_valid_o     (data_valid_o),
    .data_last_o      (data_last_o)
  );

endmodule

//--- verif/rpc_phy_tb.sv
// Testbench for the PHY core
// Replays the commands listed in verif/rpc_phy_tests.txt against the DUT
// Expected DB beats and read words follow the burst timing from the acceptance edge

`timescale 1ns/1ps

module rpc_phy_tb;
  import rpc_dram_pkg::*;

  localparam int WORD_WIDTH = 256;
  localparam int BEATS      = WORD_WIDTH / 32;
  localparam int MAX_WORDS  = 8;
  // Cycles allowed for any wait on the DUT
  localparam int TIMEOUT    = 100;

  typedef logic [WORD_WIDTH-1:0] val_t;

  logic      clk_0_i;
  logic      rst_ni;
  cmd_t      cmd_i;
  logic      cmd_valid_i;
  logic      cmd_ready_o;
  val_t      data_i;
  mask_t     mask_i;
  logic      data_ready_o;
  val_t      data_o;
  logic      data_valid_o;
  logic      data_last_o;
  logic      cs_n_o;
  logic      stb_o;
  logic      db_oe_o;
  db_slice_t db_o;
  db_slice_t rd_slice_i;
  logic      rd_slice_valid_i;

  integer seed;
  int     errors;
  int     n_tests;
  int     n_bad;
  val_t   words [MAX_WORDS];
  // Last word handed out by a read, data_o must hold it until the next one
  val_t   last_rd_word;

  rpc_phy #(
    .WORD_WIDTH (WORD_WIDTH)
  ) dut_i (.*);

  initial begin
    clk_0_i = 1'b0;
    forever #4 clk_0_i = ~clk_0_i;
  end

  //////////////////////////////////////////////////////////////////////
  // Checking helpers
  //////////////////////////////////////////////////////////////////////

  task automatic check(input val_t got, input val_t exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("FAILED at %0t: %s is %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  // Beat j of a word on DB, bits 15:0 of the slice go in the upper half
  function automatic val_t expected_beat(val_t w, int j);
    return val_t'({w[32*j +: 16], w[32*j+16 +: 16]});
  endfunction

  function automatic val_t random_word();
    val_t w;
    for (int b = 0; b < BEATS; b++) begin
      w[32*b +: 32] = $random(seed);
    end
    return w;
  endfunction

  task automatic check_pins(input logic stb, input logic cs_n, input logic oe, input logic rdy);
    check(val_t'(stb_o), val_t'(stb), "stb_o");
    check(val_t'(cs_n_o), val_t'(cs_n), "cs_n_o");
    check(val_t'(db_oe_o), val_t'(oe), "db_oe_o");
    check(val_t'(cmd_ready_o), val_t'(rdy), "cmd_ready_o");
  endtask

  // No read running, so the read outputs stay put
  task automatic check_read_idle();
    check(val_t'(data_valid_o), '0, "data_valid_o outside a read");
    check(val_t'(data_last_o), '0, "data_last_o outside a read");
    check(data_o, last_rd_word, "data_o outside a read");
  endtask

  // Junk on the read slice inputs, the packer must drop it
  task automatic drive_stray();
    rd_slice_valid_i = 1'($random(seed));
    rd_slice_i       = $random(seed);
  endtask

  task automatic stray_idle(input int cycles);
    for (int i = 0; i < cycles; i++) begin
      drive_stray();
      @(negedge clk_0_i);
      check_read_idle();
    end
  endtask

  task automatic wait_cmd_ready(output bit ok);
    int n;
    n = 0;
    while (cmd_ready_o !== 1'b1 && n < TIMEOUT) begin
      @(negedge clk_0_i);
      n++;
    end
    ok = (cmd_ready_o === 1'b1);
    if (!ok) begin
      errors++;
      $display("Timeout at %0t: cmd_ready_o stayed low for %0d cycles", $time, TIMEOUT);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Command sequences, each starts at a falling edge
  //////////////////////////////////////////////////////////////////////

  // Handshake in cycle 0, checks the command beat, returns in cycle 2
  task automatic send_command(input cmd_t cmd, input mask_t mask, output bit ok);
    wait_cmd_ready(ok);
    if (ok) begin
      cmd_i            = cmd;
      mask_i           = mask;
      cmd_valid_i      = 1'b1;
      rd_slice_valid_i = 1'b0;
      @(negedge clk_0_i);
      // Mask is captured at acceptance, later changes must not show
      cmd_valid_i = 1'b0;
      cmd_i       = cmd_t'($random(seed));
      mask_i      = {$random(seed), $random(seed)};
      check_read_idle();
      check_pins(1'b1, 1'b0, 1'b1, 1'b0);
      check(val_t'(db_o), val_t'(cmd), "command beat");
      check(val_t'(data_ready_o), '0, "data_ready_o in command beat");
      @(negedge clk_0_i);
    end
  endtask

  task automatic run_write(input cmd_t cmd, input mask_t mask);
    int   n;
    int   w;
    int   j;
    logic exp_rdy;
    n = int'(cmd.burst_len) + 1;
    for (int i = 0; i < n; i++) begin
      words[i] = random_word();
    end
    for (int k = 2; k <= 4 + BEATS * n; k++) begin
      check_read_idle();
      // Request in cycle 3 and in the last beat of every word but the last
      exp_rdy = (k >= 3) && ((k - 3) % BEATS == 0) && (k < 3 + BEATS * n);
      check(val_t'(data_ready_o), val_t'(exp_rdy), $sformatf("data_ready_o in cycle %0d", k));
      if (k == 4 + BEATS * n) begin
        check_pins(1'b0, 1'b1, 1'b0, 1'b1);
      end else begin
        check_pins(1'b0, 1'b0, 1'b1, 1'b0);
        if (k == 2) begin
          check(val_t'(db_o), expected_beat(val_t'(mask), 0), "first mask beat");
        end else if (k == 3) begin
          check(val_t'(db_o), expected_beat(val_t'(mask), 1), "second mask beat");
        end else begin
          w = (k - 4) / BEATS;
          j = (k - 4) % BEATS;
          check(val_t'(db_o), expected_beat(words[w], j), $sformatf("word %0d beat %0d", w, j));
        end
      end
      // Word valid only in its request cycle
      if (exp_rdy) begin
        data_i = words[(k - 3) / BEATS];
      end else begin
        data_i = random_word();
      end
      drive_stray();
      @(negedge clk_0_i);
    end
  endtask

  task automatic run_read(input cmd_t cmd);
    int   n;
    int   w;
    int   s;
    int   gap;
    logic exp_valid;
    logic exp_last;
    n = int'(cmd.burst_len) + 1;
    for (int i = 0; i < n; i++) begin
      words[i] = random_word();
    end
    w         = 0;
    s         = 0;
    gap       = $random(seed) & 3;
    exp_valid = 1'b0;
    exp_last  = 1'b0;
    while (w < n || exp_valid) begin
      // Bus released from cycle 2, chip select held until the last word
      check_pins(1'b0, w == n, 1'b0, w == n);
      check(val_t'(data_valid_o), val_t'(exp_valid), "data_valid_o");
      check(val_t'(data_last_o), val_t'(exp_last), "data_last_o");
      if (exp_valid) begin
        check(data_o, words[w-1], $sformatf("read word %0d", w - 1));
      end
      exp_valid        = 1'b0;
      exp_last         = 1'b0;
      rd_slice_valid_i = 1'b0;
      rd_slice_i       = $random(seed);
      if (w < n && gap > 0) begin
        gap--;
      end else if (w < n) begin
        rd_slice_valid_i = 1'b1;
        rd_slice_i       = words[w][32*s +: 32];
        gap              = $random(seed) & 3;
        if (s == BEATS - 1) begin
          exp_valid = 1'b1;
          exp_last  = (w == n - 1);
          s         = 0;
          w++;
        end else begin
          s++;
        end
      end
      @(negedge clk_0_i);
    end
    rd_slice_valid_i = 1'b0;
    last_rd_word     = words[n-1];
  endtask

  // Single beat only, back to idle in cycle 2
  task automatic run_cmd_only();
    check_read_idle();
    check_pins(1'b0, 1'b1, 1'b0, 1'b1);
    check(val_t'(db_o), '0, "db_o after command beat");
  endtask

  task automatic report_test(input string name, input int errs_before);
    n_tests++;
    if (errors != errs_before) begin
      n_bad++;
      $display("test %0d %s: %0d mismatches", n_tests, name, errors - errs_before);
    end else begin
      $display("test %0d %s: ok", n_tests, name);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    int          fd;
    int          rc;
    int          errs_before;
    string       line;
    byte         op;
    logic [31:0] cmd_word;
    logic [31:0] line_seed;
    logic [63:0] mask_word;
    bit          ok;
    bit          halted;
    seed             = 32'h31f0_2a9b;
    errors           = 0;
    n_tests          = 0;
    n_bad            = 0;
    halted           = 1'b0;
    last_rd_word     = 'x;
    rst_ni           = 1'b0;
    cmd_i            = '0;
    cmd_valid_i      = 1'b0;
    data_i           = '0;
    mask_i           = '0;
    rd_slice_i       = '0;
    rd_slice_valid_i = 1'b0;
    repeat (16) @(posedge clk_0_i);
    @(negedge clk_0_i);
    rst_ni = 1'b1;
    @(negedge clk_0_i);

    errs_before = errors;
    check_pins(1'b0, 1'b1, 1'b0, 1'b1);
    check(val_t'(data_ready_o), '0, "data_ready_o after reset");
    check(val_t'(data_valid_o), '0, "data_valid_o after reset");
    check(val_t'(data_last_o), '0, "data_last_o after reset");
    check(val_t'(db_o), '0, "db_o after reset");
    report_test("reset", errs_before);

    fd = $fopen("verif/rpc_phy_tests.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("Could not open the test file verif/rpc_phy_tests.txt");
      halted = 1'b1;
    end
    while (!halted && !$feof(fd)) begin
      rc = $fgets(line, fd);
      // Comment and blank lines carry no test
      if (rc > 0 && line.getc(0) != "#") begin
        rc = $sscanf(line, "%c %h %h %h", op, cmd_word, mask_word, line_seed);
      end else begin
        rc = 0;
      end
      if (rc == 4) begin
        seed        = 32'h31f0_2a9b + line_seed;
        errs_before = errors;
        stray_idle(3);
        send_command(cmd_t'(cmd_word), mask_word, ok);
        if (!ok) begin
          halted = 1'b1;
        end else if (op == "W") begin
          run_write(cmd_t'(cmd_word), mask_word);
        end else if (op == "R") begin
          run_read(cmd_t'(cmd_word));
        end else begin
          run_cmd_only();
        end
        report_test($sformatf("%c %h", op, cmd_word), errs_before);
      end
    end
    if (fd != 0) begin
      $fclose(fd);
    end
    if (!halted && n_tests < 2) begin
      errors++;
      $display("No tests were read from the test file");
    end

    $display("tests %0d, failing %0d, mismatches %0d", n_tests, n_bad, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

//--- verif/rpc_phy_tests.txt
# op cmd mask seed: op is W write, R read, C command-only; cmd and mask in hex
# seed (hex) is added to the base seed to generate the data words of the test
W 40001234 ffff0000a5a5c3c3 0001
C 00000042 0000000000000000 0002
W 48a01c00 0123456789abcdef 0003
R 80000100 0000000000000000 0004
W 50123456 fedcba9876543210 0005
R 88002000 1111111111111111 0006
W 58004000 00ff00ff00ff00ff 0007
C c1234567 aaaaaaaaaaaaaaaa 0008
W 600aa000 8000000000000001 0009
R 98000040 0000000000000000 000a
W 68000008 3c3c3c3c5a5a5a5a 000b
W 70fff000 0f0f0f0ff0f0f0f0 000c
R a0001000 ffffffffffffffff 000d
W 78000000 deadbeefcafef00d 000e
C fffffff0 0000000000000000 000f
R b8000000 0000000000000000 0010
C 3a5a5a5a 5555555555555555 0011
W 4c000010 1234567812345678 0012
R 80abcdef 0000000000000000 0013
W 78123456 ffffffffffffffff 0014
C 0000ffff 0000000000000000 0015

//--- rpc_phy.f
hdl/rpc_dram_pkg.sv
hdl/rpc_phy_pkg.sv
hdl/rpc_burst_seq.sv
hdl/rpc_tx_mux.sv
hdl/rpc_rx_pack.sv
hdl/rpc_phy.sv
verif/rpc_phy_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the PHY testbench with Verilator, runs it and looks for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module rpc_phy_tb -f rpc_phy.f -o rpc_phy_sim \
  || { echo "Verilator build failed"; exit 1; }

out=$(./obj_dir/rpc_phy_sim)
echo "$out"
echo "$out" | grep -qxF '** PASS **' && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }
